//--- files.f
+incdir+include
hw/fetch_pkg.sv
hw/arm_isa_pkg.sv
hw/inst_memory.sv
hw/fetch_unit.sv
hw/inst_queue.sv
hw/inst_decoder.sv
hw/fetch_decode_top.sv
test/tb_fetch_decode.sv

//--- hw/arm_isa_pkg.sv
package arm_isa_pkg;

	// Condition field, bits 31..28
	typedef enum logic [3:0] {
		cond_eq = 4'h0,                        // Z set
		cond_ne = 4'h1,                        // Z clear
		cond_cs = 4'h2,                        // C set
		cond_cc = 4'h3,                        // C clear
		cond_mi = 4'h4,                        // N set
		cond_pl = 4'h5,                        // N clear
		cond_vs = 4'h6,                        // V set
		cond_vc = 4'h7,                        // V clear
		cond_hi = 4'h8,                        // C set and Z clear
		cond_ls = 4'h9,                        // C clear or Z set
		cond_ge = 4'ha,                        // N equals V
		cond_lt = 4'hb,                        // N differs from V
		cond_gt = 4'hc,                        // Z clear and N equals V
		cond_le = 4'hd,                        // Z set or N differs from V
		cond_al = 4'he,                        // Always
		cond_nv = 4'hf                         // Never
	} cond_e;

	// Data-processing opcode, bits 24..21
	typedef enum logic [3:0] {
		op_and = 4'h0,
		op_eor = 4'h1,
		op_sub = 4'h2,
		op_rsb = 4'h3,
		op_add = 4'h4,
		op_adc = 4'h5,
		op_sbc = 4'h6,
		op_rsc = 4'h7,
		op_tst = 4'h8,                         // Compare-type ops write no destination
		op_teq = 4'h9,
		op_cmp = 4'ha,
		op_cmn = 4'hb,
		op_orr = 4'hc,
		op_mov = 4'hd,
		op_bic = 4'he,
		op_mvn = 4'hf
	} opcode_e;

	// Instruction class from bits 27..26
	typedef enum logic [1:0] {
		class_data_proc = 2'b00,
		class_mem_xfer  = 2'b01,
		class_branch    = 2'b10,
		class_undefined = 2'b11
	} inst_class_e;

	typedef logic [3:0]  reg_idx_t;            // R0..R15
	typedef logic [11:0] operand_t;            // Shifter operand or memory offset

	// Fully split instruction as offered to the outside
	typedef struct packed {
		fetch_pkg::addr_t address;             // Where the word was fetched from
		cond_e            cond;
		inst_class_e      inst_class;
		opcode_e          opcode;
		logic             set_flags;           // S bit, data processing only
		logic             imm;                 // Bit 25
		logic             load;                // L bit, memory transfers only
		reg_idx_t         rn;
		reg_idx_t         rd;
		operand_t         operand;
		fetch_pkg::addr_t branch_target;       // Zero unless class is branch
	} decoded_inst_t;

endpackage

//--- hw/fetch_decode_top.sv
module fetch_decode_top #(
	parameter int MEM_WORDS   = 64,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                       clk,
	input  logic                       rst_n,
	output logic                       dec_req,
	input  logic                       dec_ack,
	output arm_isa_pkg::decoded_inst_t dec_inst
);
	import fetch_pkg::*;

	logic       fetch_req;                     // Link 1, fetch to queue
	logic       fetch_ack;
	fetch_pkt_t fetch_pkt;
	logic       queue_req;                     // Link 2, queue to decoder
	logic       queue_ack;
	fetch_pkt_t queue_pkt;

	fetch_unit #(
		.MEM_WORDS(MEM_WORDS)
	) i_fetch (
		.clk(clk),
		.rst_n(rst_n),
		.fetch_req(fetch_req),
		.fetch_ack(fetch_ack),
		.fetch_pkt(fetch_pkt)
	);

	inst_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) i_queue (
		.clk(clk),
		.rst_n(rst_n),
		.in_req(fetch_req),
		.in_ack(fetch_ack),
		.in_pkt(fetch_pkt),
		.out_req(queue_req),
		.out_ack(queue_ack),
		.out_pkt(queue_pkt)
	);

	inst_decoder i_decoder (
		.clk(clk),
		.rst_n(rst_n),
		.in_req(queue_req),
		.in_ack(queue_ack),
		.in_pkt(queue_pkt),
		.dec_req(dec_req),
		.dec_ack(dec_ack),
		.dec_inst(dec_inst)
	);

endmodule

//--- hw/fetch_pkg.sv
package fetch_pkg;

	// Byte address of an instruction word
	typedef logic [31:0] addr_t;

	// Raw 32-bit instruction as stored in the ROM
	typedef logic [31:0] inst_word_t;

	// One fetched word together with the address it came from
	typedef struct packed {
		addr_t      addr;                      // Byte address, low two bits always zero
		inst_word_t word;                      // Instruction bits as read from the ROM
	} fetch_pkt_t;

endpackage

//--- hw/fetch_unit.sv
module fetch_unit #(
	parameter int MEM_WORDS = 64
) (
	input  logic                  clk,
	input  logic                  rst_n,
	output logic                  fetch_req,
	input  logic                  fetch_ack,
	output fetch_pkg::fetch_pkt_t fetch_pkt
);
	import fetch_pkg::*;

	localparam addr_t LAST_ADDR = addr_t'((MEM_WORDS - 1) * 4); // Address of the final word

	typedef enum logic [1:0] {
		st_idle,                               // Load packet and raise req
		st_offer,                              // Req high, waiting for ack
		st_wait_release                        // Req low, waiting for ack to fall
	} state_e;

	state_e     state;
	addr_t      pc;
	addr_t      next_pc;
	inst_word_t rom_word;

	inst_memory #(
		.MEM_WORDS(MEM_WORDS)
	) i_rom (
		.addr(pc),
		.inst(rom_word)
	);

	// Sequential fetch only, wrap at the end of the ROM
	assign next_pc = (pc == LAST_ADDR) ? '0 : pc + addr_t'(4);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state     <= st_idle;
			pc        <= '0;
			fetch_req <= 1'b0;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					fetch_pkt <= '{addr: pc, word: rom_word}; // Data settles with req
					fetch_req <= 1'b1;
					state     <= st_offer;
				end
				st_offer:
				begin
					if (fetch_ack)
					begin
						fetch_req <= 1'b0;     // Queue has the word
						pc        <= next_pc;
						state     <= st_wait_release;
					end
				end
				st_wait_release:
				begin
					if (!fetch_ack)
						state <= st_idle;      // Four-phase cycle closed
				end
				default:
					state <= st_idle;
			endcase
		end
	end

endmodule

//--- hw/inst_decoder.sv
module inst_decoder (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       in_req,
	output logic                       in_ack,
	input  fetch_pkg::fetch_pkt_t      in_pkt,
	output logic                       dec_req,
	input  logic                       dec_ack,
	output arm_isa_pkg::decoded_inst_t dec_inst
);
	import fetch_pkg::*;
	import arm_isa_pkg::*;

	typedef enum logic [1:0] {
		st_idle,                               // Free to take the next word
		st_load,                               // Result registered, req follows
		st_offer,                              // Dec_req high, result held
		st_release                             // Waiting for dec_ack to fall
	} state_e;

	state_e        state;
	inst_word_t    word;
	addr_t         br_offset;
	decoded_inst_t decoded;

	assign word = in_pkt.word;

	// Signed 24-bit word offset scaled to bytes
	assign br_offset = addr_t'({{6{word[23]}}, word[23:0], 2'b00});

	always_comb
	begin
		decoded            = '0;
		decoded.address    = in_pkt.addr;
		decoded.cond       = cond_e'(word[31:28]);
		decoded.opcode     = opcode_e'(word[24:21]);
		decoded.imm        = word[25];
		decoded.rn         = word[19:16];
		decoded.rd         = word[15:12];
		decoded.operand    = word[11:0];
		case (word[27:26])
			2'b00:
			begin
				decoded.inst_class = class_data_proc;
				decoded.set_flags  = word[20]; // S bit
			end
			2'b01:
			begin
				decoded.inst_class = class_mem_xfer;
				decoded.load       = word[20]; // Same bit means L here
			end
			2'b10:
			begin
				decoded.inst_class    = class_branch;
				decoded.branch_target = in_pkt.addr + addr_t'(8) + br_offset; // PC reads two ahead
			end
			default:
				decoded.inst_class = class_undefined;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state   <= st_idle;
			in_ack  <= 1'b0;
			dec_req <= 1'b0;
		end
		else
		begin
			if (in_ack && !in_req)
				in_ack <= 1'b0;                // Queue side completes on its own
			case (state)
				st_idle:
				begin
					// Ack still high means the old transfer is not closed
					if (in_req && !in_ack)
					begin
						in_ack   <= 1'b1;
						dec_inst <= decoded;
						state    <= st_load;
					end
				end
				st_load:
				begin
					dec_req <= 1'b1;
					state   <= st_offer;
				end
				st_offer:
				begin
					if (dec_ack)
					begin
						dec_req <= 1'b0;
						state   <= st_release;
					end
				end
				st_release:
				begin
					if (!dec_ack)
						state <= st_idle;
				end
				default:
					state <= st_idle;
			endcase
		end
	end

endmodule

//--- hw/inst_memory.sv
module inst_memory #(
	parameter int MEM_WORDS = 64
) (
	input  fetch_pkg::addr_t      addr,
	output fetch_pkg::inst_word_t inst
);
	import fetch_pkg::*;

	inst_word_t rom [MEM_WORDS];               // Word-addressed program store
	addr_t      word_idx;                      // Word index after dropping byte offset

	initial
	begin
		for (int i = 0; i < MEM_WORDS; i++)
		begin
			rom[i] = '0;                       // Unused words read back as zero
		end
		`include "inst_program.svh"
	end

	// Low two address bits ignored, index folds back into the ROM
	assign word_idx = (addr >> 2) % MEM_WORDS;

	assign inst = rom[word_idx];               // Combinational read

endmodule

//--- hw/inst_queue.sv
module inst_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_req,
	output logic                  in_ack,
	input  fetch_pkg::fetch_pkt_t in_pkt,
	output logic                  out_req,
	input  logic                  out_ack,
	output fetch_pkg::fetch_pkt_t out_pkt
);
	import fetch_pkg::*;

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = PTR_W + 1;          // Holds 0..QUEUE_DEPTH

	typedef enum logic {
		wr_idle,                               // Ready to accept a packet
		wr_hold                                // Ack high until req falls
	} wr_state_e;

	typedef enum logic [1:0] {
		rd_idle,                               // Waiting for a stored entry
		rd_offer,                              // Head offered downstream
		rd_release                             // Waiting for ack to fall
	} rd_state_e;

	fetch_pkt_t       entries [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	wr_state_e        wr_state;
	rd_state_e        rd_state;
	logic             full;
	logic             push;
	logic             pop;

	assign full = (count == CNT_W'(QUEUE_DEPTH));
	assign push = (wr_state == wr_idle) && in_req && !full; // Back-pressure by withholding ack
	assign pop  = (rd_state == rd_offer) && out_ack;

	// Head entry cannot be overwritten before it is popped
	assign out_pkt = entries[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (push)
			entries[wr_ptr] <= in_pkt;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_state <= wr_idle;
			rd_state <= rd_idle;
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			in_ack   <= 1'b0;
			out_req  <= 1'b0;
		end
		else
		begin
			count <= count + CNT_W'(push) - CNT_W'(pop);
			if (push)
			begin
				wr_ptr   <= wr_ptr + 1'b1;     // Power-of-two depth wraps for free
				in_ack   <= 1'b1;
				wr_state <= wr_hold;
			end
			else if (wr_state == wr_hold && !in_req)
			begin
				in_ack   <= 1'b0;
				wr_state <= wr_idle;
			end
			case (rd_state)
				rd_idle:
				begin
					if (count != '0)
					begin
						out_req  <= 1'b1;
						rd_state <= rd_offer;
					end
				end
				rd_offer:
				begin
					if (out_ack)
					begin
						out_req  <= 1'b0;
						rd_ptr   <= rd_ptr + 1'b1; // Head consumed
						rd_state <= rd_release;
					end
				end
				rd_release:
				begin
					if (!out_ack)
						rd_state <= rd_idle;
				end
				default:
					rd_state <= rd_idle;
			endcase
		end
	end

endmodule

//--- include/inst_program.svh
`ifndef INST_PROGRAM_SVH
`define INST_PROGRAM_SVH

// Setup and plain ALU work
rom[0]  = 32'b1110_00_1_1101_0_0000_0000_000000010100; // MOV   R0, #20
rom[1]  = 32'b1110_00_1_1101_0_0000_0001_000000000011; // MOV   R1, #3
rom[2]  = 32'b1110_00_1_1101_0_0000_0010_110000000001; // MOV   R2, #0x100
rom[3]  = 32'b1110_00_0_0100_1_0000_0011_000000000001; // ADDS  R3, R0, R1
rom[4]  = 32'b1110_00_0_0010_0_0011_0100_000100000001; // SUB   R4, R3, R1, LSL #2
rom[5]  = 32'b1110_00_0_0010_0_0000_0101_000000000001; // SUB   R5, R0, R1
rom[6]  = 32'b1110_00_0_0011_0_0001_0110_000000000000; // RSB   R6, R1, R0
rom[7]  = 32'b1110_00_0_0000_0_0000_0111_000000000001; // AND   R7, R0, R1
rom[8]  = 32'b1110_00_0_1100_0_0000_1000_000010100001; // ORR   R8, R0, R1, LSR #1
rom[9]  = 32'b1110_00_0_0001_0_1000_1001_000000000111; // EOR   R9, R8, R7
rom[10] = 32'b1110_00_0_1111_0_0000_1010_000000001001; // MVN   R10, R9
rom[11] = 32'b1110_00_1_1110_0_0000_1011_000000000100; // BIC   R11, R0, #4
rom[12] = 32'b1110_00_0_1010_1_0011_0000_000000000001; // CMP   R3, R1
rom[13] = 32'b0001_00_0_0100_0_0001_0001_000000000001; // ADDNE R1, R1, R1
rom[14] = 32'b1110_00_0_1000_1_0000_0000_000000000001; // TST   R0, R1
rom[15] = 32'b0000_00_1_1101_0_0000_1100_000000000001; // MOVEQ R12, #1
// Scratch area at R2
rom[16] = 32'b1110_01_0_0100_0_0010_0001_000000000000; // STR   R1, [R2], #0
rom[17] = 32'b1110_01_0_0100_0_0010_0011_000000000100; // STR   R3, [R2], #4
rom[18] = 32'b1110_01_0_0100_0_0010_0100_000000001000; // STR   R4, [R2], #8
rom[19] = 32'b1110_01_0_0100_1_0010_0101_000000000000; // LDR   R5, [R2], #0
rom[20] = 32'b1110_01_0_0100_1_0010_0110_000000000100; // LDR   R6, [R2], #4
rom[21] = 32'b1110_00_1_1101_0_0000_0011_000000000000; // MOV   R3, #0
rom[22] = 32'b1110_00_1_1101_0_0000_0100_000000000000; // MOV   R4, #0
// Bubble pass over three words
rom[23] = 32'b1110_00_0_0100_0_0010_0111_000100000011; // ADD   R7, R2, R3, LSL #2
rom[24] = 32'b1110_01_0_0100_1_0111_1000_000000000000; // LDR   R8, [R7], #0
rom[25] = 32'b1110_01_0_0100_1_0111_1001_000000000100; // LDR   R9, [R7], #4
rom[26] = 32'b1110_00_0_1010_1_1000_0000_000000001001; // CMP   R8, R9
rom[27] = 32'b1100_01_0_0100_0_0111_1001_000000000000; // STRGT R9, [R7], #0
rom[28] = 32'b1100_01_0_0100_0_0111_1000_000000000100; // STRGT R8, [R7], #4
rom[29] = 32'b1110_00_1_0100_0_0011_0011_000000000001; // ADD   R3, R3, #1
rom[30] = 32'b1110_00_1_1010_1_0011_0000_000000000010; // CMP   R3, #2
rom[31] = 32'b1011_10_1_0_1111_1111_1111_1111_1111_0110; // BLT   #-10
rom[32] = 32'b1110_00_1_1101_0_0000_0011_000000000000; // MOV   R3, #0
rom[33] = 32'b1110_00_1_0100_0_0100_0100_000000000001; // ADD   R4, R4, #1
rom[34] = 32'b1110_00_0_1010_1_0100_0000_000000000001; // CMP   R4, R1
rom[35] = 32'b1011_10_1_0_1111_1111_1111_1111_1111_0010; // BLT   #-14
// Sum the sorted words
rom[36] = 32'b1110_01_0_0100_1_0010_1010_000000000000; // LDR   R10, [R2], #0
rom[37] = 32'b1110_01_0_0100_1_0010_1011_000000000100; // LDR   R11, [R2], #4
rom[38] = 32'b1110_01_0_0100_1_0010_1100_000000001000; // LDR   R12, [R2], #8
rom[39] = 32'b1110_00_0_0100_0_1010_0000_000000001011; // ADD   R0, R10, R11
rom[40] = 32'b1110_00_0_0100_1_0000_0000_000000001100; // ADDS  R0, R0, R12
rom[41] = 32'b1110_01_0_0100_0_0010_0000_000000001100; // STR   R0, [R2], #12
rom[42] = 32'b1110_00_1_1101_0_0000_0001_000011111111; // MOV   R1, #0xFF
rom[43] = 32'b1110_00_0_1001_1_0001_0000_000000000000; // TEQ   R1, R0
rom[44] = 32'b1110_10_1_0_1111_1111_1111_1111_1111_1111; // B     #-1

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch/decode testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f files.f \
	--top-module tb_fetch_decode -o tb_fetch_decode

./obj_dir/tb_fetch_decode | tee sim.log

if grep -q "Test failures found" sim.log; then
	echo "Simulation FAILED"
	exit 1
fi
echo "Simulation PASSED"

//--- test/tb_fetch_decode.sv
module tb_fetch_decode;
	timeunit 1ns;
	timeprecision 1ps;

	import fetch_pkg::*;
	import arm_isa_pkg::*;

	localparam int MEM_WORDS   = 64;
	localparam int QUEUE_DEPTH = 4;
	localparam int PROG_WORDS  = 45;               // Words listed in inst_program.svh
	localparam int ROWS        = MEM_WORDS + 4;    // Runs four words past the wrap
	localparam int BP_ROW      = 20;               // Transfer held back for a long stretch
	localparam int BP_CYCLES   = 30;
	localparam int WATCHDOG_NS = (ROWS * 40 + 200) * 10;

	logic          clk = 1'b0;
	logic          rst_n;
	logic          dec_req;
	logic          dec_ack;
	decoded_inst_t dec_inst;

	decoded_inst_t exp_q [$];                      // Expected transfers in arrival order
	logic [31:0]   rnd_state = 32'd37;
	int            errors = 0;
	int            tests_run = 0;
	int            tests_failed = 0;

	fetch_decode_top #(
		.MEM_WORDS(MEM_WORDS),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.dec_req(dec_req),
		.dec_ack(dec_ack),
		.dec_inst(dec_inst)
	);

	initial
	begin
		forever #5 clk = ~clk;                     // 10 ns period
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic add_row(input addr_t a, input cond_e c, input inst_class_e k,
		input opcode_e o, input logic s, input logic i, input logic l,
		input reg_idx_t rn, input reg_idx_t rd, input operand_t op, input addr_t tgt);
		decoded_inst_t r;
		r.address       = a;
		r.cond          = c;
		r.inst_class    = k;
		r.opcode        = o;
		r.set_flags     = s;
		r.imm           = i;
		r.load          = l;
		r.rn            = rn;
		r.rd            = rd;
		r.operand       = op;
		r.branch_target = tgt;
		exp_q.push_back(r);
	endtask

	// One row per word of the program listing
	task automatic build_table();
		add_row('h00, cond_al, class_data_proc, op_mov, 0, 1, 0, 0, 0, 'h014, 'h0);
		add_row('h04, cond_al, class_data_proc, op_mov, 0, 1, 0, 0, 1, 'h003, 'h0);
		add_row('h08, cond_al, class_data_proc, op_mov, 0, 1, 0, 0, 2, 'hC01, 'h0);
		add_row('h0C, cond_al, class_data_proc, op_add, 1, 0, 0, 0, 3, 'h001, 'h0); // ADDS
		add_row('h10, cond_al, class_data_proc, op_sub, 0, 0, 0, 3, 4, 'h101, 'h0); // LSL #2
		add_row('h14, cond_al, class_data_proc, op_sub, 0, 0, 0, 0, 5, 'h001, 'h0);
		add_row('h18, cond_al, class_data_proc, op_rsb, 0, 0, 0, 1, 6, 'h000, 'h0);
		add_row('h1C, cond_al, class_data_proc, op_and, 0, 0, 0, 0, 7, 'h001, 'h0);
		add_row('h20, cond_al, class_data_proc, op_orr, 0, 0, 0, 0, 8, 'h0A1, 'h0);
		add_row('h24, cond_al, class_data_proc, op_eor, 0, 0, 0, 8, 9, 'h007, 'h0);
		add_row('h28, cond_al, class_data_proc, op_mvn, 0, 0, 0, 0, 10, 'h009, 'h0);
		add_row('h2C, cond_al, class_data_proc, op_bic, 0, 1, 0, 0, 11, 'h004, 'h0);
		add_row('h30, cond_al, class_data_proc, op_cmp, 1, 0, 0, 3, 0, 'h001, 'h0);
		add_row('h34, cond_ne, class_data_proc, op_add, 0, 0, 0, 1, 1, 'h001, 'h0); // ADDNE
		add_row('h38, cond_al, class_data_proc, op_tst, 1, 0, 0, 0, 0, 'h001, 'h0);
		add_row('h3C, cond_eq, class_data_proc, op_mov, 0, 1, 0, 0, 12, 'h001, 'h0);
		add_row('h40, cond_al, class_mem_xfer, op_add, 0, 0, 0, 2, 1, 'h000, 'h0); // STR
		add_row('h44, cond_al, class_mem_xfer, op_add, 0, 0, 0, 2, 3, 'h004, 'h0);
		add_row('h48, cond_al, class_mem_xfer, op_add, 0, 0, 0, 2, 4, 'h008, 'h0);
		add_row('h4C, cond_al, class_mem_xfer, op_add, 0, 0, 1, 2, 5, 'h000, 'h0); // LDR
		add_row('h50, cond_al, class_mem_xfer, op_add, 0, 0, 1, 2, 6, 'h004, 'h0);
		add_row('h54, cond_al, class_data_proc, op_mov, 0, 1, 0, 0, 3, 'h000, 'h0);
		add_row('h58, cond_al, class_data_proc, op_mov, 0, 1, 0, 0, 4, 'h000, 'h0);
		add_row('h5C, cond_al, class_data_proc, op_add, 0, 0, 0, 2, 7, 'h103, 'h0);
		add_row('h60, cond_al, class_mem_xfer, op_add, 0, 0, 1, 7, 8, 'h000, 'h0);
		add_row('h64, cond_al, class_mem_xfer, op_add, 0, 0, 1, 7, 9, 'h004, 'h0);
		add_row('h68, cond_al, class_data_proc, op_cmp, 1, 0, 0, 8, 0, 'h009, 'h0);
		add_row('h6C, cond_gt, class_mem_xfer, op_add, 0, 0, 0, 7, 9, 'h000, 'h0); // STRGT
		add_row('h70, cond_gt, class_mem_xfer, op_add, 0, 0, 0, 7, 8, 'h004, 'h0);
		add_row('h74, cond_al, class_data_proc, op_add, 0, 1, 0, 3, 3, 'h001, 'h0);
		add_row('h78, cond_al, class_data_proc, op_cmp, 1, 1, 0, 3, 0, 'h002, 'h0);
		add_row('h7C, cond_lt, class_branch, op_rsc, 0, 1, 0, 15, 15, 'hFF6, 'h5C); // 7C+8-40
		add_row('h80, cond_al, class_data_proc, op_mov, 0, 1, 0, 0, 3, 'h000, 'h0);
		add_row('h84, cond_al, class_data_proc, op_add, 0, 1, 0, 4, 4, 'h001, 'h0);
		add_row('h88, cond_al, class_data_proc, op_cmp, 1, 0, 0, 4, 0, 'h001, 'h0);
		add_row('h8C, cond_lt, class_branch, op_rsc, 0, 1, 0, 15, 15, 'hFF2, 'h5C); // 8C+8-56
		add_row('h90, cond_al, class_mem_xfer, op_add, 0, 0, 1, 2, 10, 'h000, 'h0);
		add_row('h94, cond_al, class_mem_xfer, op_add, 0, 0, 1, 2, 11, 'h004, 'h0);
		add_row('h98, cond_al, class_mem_xfer, op_add, 0, 0, 1, 2, 12, 'h008, 'h0);
		add_row('h9C, cond_al, class_data_proc, op_add, 0, 0, 0, 10, 0, 'h00B, 'h0);
		add_row('hA0, cond_al, class_data_proc, op_add, 1, 0, 0, 0, 0, 'h00C, 'h0);
		add_row('hA4, cond_al, class_mem_xfer, op_add, 0, 0, 0, 2, 0, 'h00C, 'h0);
		add_row('hA8, cond_al, class_data_proc, op_mov, 0, 1, 0, 0, 1, 'h0FF, 'h0);
		add_row('hAC, cond_al, class_data_proc, op_teq, 1, 0, 0, 1, 0, 'h000, 'h0);
		add_row('hB0, cond_al, class_branch, op_rsc, 0, 1, 0, 15, 15, 'hFFF, 'hB4); // B #-1
		for (int i = PROG_WORDS; i < MEM_WORDS; i++)
			add_row(addr_t'(4 * i), cond_eq, class_data_proc, op_and, 0, 0, 0, 0, 0, 0, 0);
		for (int i = 0; i < ROWS - MEM_WORDS; i++)
			exp_q.push_back(exp_q[i]);             // Program starts over once the PC wraps
	endtask

	task automatic check_addr(input string sig, input addr_t exp, input addr_t act);
		if (act !== exp)
		begin
			$display("ERR t=%0t %s expected %h got %h", $time, sig, exp, act);
			errors++;
		end
	endtask

	task automatic check_cond(input string sig, input cond_e exp, input cond_e act);
		if (act !== exp)
		begin
			$display("ERR t=%0t %s expected %s got %s", $time, sig, exp.name(), act.name());
			errors++;
		end
	endtask

	task automatic check_class(input string sig, input inst_class_e exp,
		input inst_class_e act);
		if (act !== exp)
		begin
			$display("ERR t=%0t %s expected %s got %s", $time, sig, exp.name(), act.name());
			errors++;
		end
	endtask

	task automatic check_opcode(input string sig, input opcode_e exp, input opcode_e act);
		if (act !== exp)
		begin
			$display("ERR t=%0t %s expected %s got %s", $time, sig, exp.name(), act.name());
			errors++;
		end
	endtask

	task automatic check_reg(input string sig, input reg_idx_t exp, input reg_idx_t act);
		if (act !== exp)
		begin
			$display("ERR t=%0t %s expected %0d got %0d", $time, sig, exp, act);
			errors++;
		end
	endtask

	task automatic check_operand(input string sig, input operand_t exp, input operand_t act);
		if (act !== exp)
		begin
			$display("ERR t=%0t %s expected %h got %h", $time, sig, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string sig, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("ERR t=%0t %s expected %b got %b", $time, sig, exp, act);
			errors++;
		end
	endtask

	task automatic check_inst(input string sig, input decoded_inst_t exp,
		input decoded_inst_t act);
		if (act !== exp)
		begin
			$display("ERR t=%0t %s expected %h got %h", $time, sig, exp, act);
			errors++;
		end
	endtask

	task automatic compare_row(input decoded_inst_t exp, input decoded_inst_t act);
		check_addr("dec_inst.address", exp.address, act.address);
		check_cond("dec_inst.cond", exp.cond, act.cond);
		check_class("dec_inst.inst_class", exp.inst_class, act.inst_class);
		check_opcode("dec_inst.opcode", exp.opcode, act.opcode);
		check_bit("dec_inst.set_flags", exp.set_flags, act.set_flags);
		check_bit("dec_inst.imm", exp.imm, act.imm);
		check_bit("dec_inst.load", exp.load, act.load);
		check_reg("dec_inst.rn", exp.rn, act.rn);
		check_reg("dec_inst.rd", exp.rd, act.rd);
		check_operand("dec_inst.operand", exp.operand, act.operand);
		check_addr("dec_inst.branch_target", exp.branch_target, act.branch_target);
	endtask

	task automatic report_test(input string name, input bit ok);
		tests_run++;
		if (!ok)
			tests_failed++;
		$display("test %-16s %s", name, ok ? "ok" : "FAILED");
	endtask

	initial
	begin
		int            delay;
		int            errs_before;
		rst_n   = 1'b0;
		dec_ack = 1'b0;
		build_table();
		repeat (8)
		begin
			@(negedge clk);
			check_bit("dec_req", 1'b0, dec_req); // Nothing offered while in reset
		end
		rst_n = 1'b1;
		@(negedge clk);
		check_bit("dec_req", 1'b0, dec_req);     // Pipeline still filling
		report_test("reset", errors == 0);
		for (int r = 0; r < ROWS; r++)
		begin
			errs_before = errors;
			while (!dec_req)
				@(negedge clk);
			rnd_state = xorshift(rnd_state);
			delay     = (r == BP_ROW) ? BP_CYCLES : int'(rnd_state % 32'd13);
			repeat (delay)
			begin
				@(negedge clk);
				check_bit("dec_req", 1'b1, dec_req);       // Offer must not be withdrawn
				check_inst("dec_inst", exp_q[r], dec_inst); // Output frozen until acked
			end
			compare_row(exp_q[r], dec_inst);
			dec_ack = 1'b1;
			while (dec_req)
				@(negedge clk);
			dec_ack = 1'b0;
			report_test($sformatf("row %0d @%h", r, exp_q[r].address), errors == errs_before);
		end
		$display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// Worst case is every row at its longest delay plus the back-pressure hold
	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the decoder handshake stalled", WATCHDOG_NS);
		$display("Test failures found");
		$finish;
	end

endmodule
